//--- dcache_ctrl.sv
// ********************
// one access in flight; addr and wdata must hold until stall falls
// ********************
`default_nettype none

module dcache_ctrl (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               access,
    input  wire                               wr,
    input  wire [dcache_pkg::addr_w-1:0]      addr,
    input  wire [dcache_pkg::word_w-1:0]      wdata,
    input  wire [dcache_pkg::tag_w-1:0]       tag0,
    input  wire [dcache_pkg::tag_w-1:0]       tag1,
    input  wire                               valid0,
    input  wire                               valid1,
    input  wire                               dirty0,
    input  wire                               dirty1,
    input  wire                               lru,
    input  wire [dcache_pkg::line_w-1:0]      line0,
    input  wire [dcache_pkg::line_w-1:0]      line1,
    input  wire                               l2_busy,
    input  wire                               l2_rdy,
    input  wire                               l2_done,
    input  wire [dcache_pkg::line_w-1:0]      l2_rdata,
    output logic                              stall,
    output logic [dcache_pkg::word_w-1:0]     rdata,
    output logic                              tag_re,
    output logic [dcache_pkg::index_w-1:0]    index,
    output logic [dcache_pkg::offset_w-1:0]   offset,
    output logic [dcache_pkg::tag_w-1:0]      tag_in,
    output logic                              fill_we,
    output dcache_pkg::way_t                  fill_way,
    output logic [dcache_pkg::line_w-1:0]     fill_line,
    output logic                              word_we,
    output dcache_pkg::way_t                  hit_way,
    output logic                              lru_we,
    output logic                              lru_val,
    output logic                              l2_req,
    output logic                              l2_wr,
    output logic [dcache_pkg::line_addr_w-1:0] l2_addr,
    output logic [dcache_pkg::line_w-1:0]     l2_wdata
);
    import dcache_pkg::*;

    dcache_addr_u      a;
    dc_state_t         state;
    dc_state_t         state_nx;
    logic              wr_q;        // wr is only valid with access
    logic              hit0;
    logic              hit1;
    logic              hit;
    logic [line_w-1:0] hit_line;
    way_t              victim;
    way_t              victim_q;
    way_t              vway;
    way_t              used_way;
    logic [tag_w-1:0]  victim_tag;
    logic              victim_dirty;

    function automatic logic [word_w-1:0] pick_word(
        input logic [line_w-1:0]   ln,
        input logic [offset_w-1:0] off
    );
        return ln[off*word_w +: word_w];
    endfunction

    assign a      = addr;
    assign index  = a.f.index;
    assign offset = a.f.offset;
    assign tag_in = a.f.tag;

    assign hit0     = valid0 && (tag0 == a.f.tag);
    assign hit1     = valid1 && (tag1 == a.f.tag);
    assign hit      = hit0 || hit1;
    assign hit_way  = hit0 ? way0 : way1;
    assign hit_line = hit0 ? line0 : line1;

    // invalid way first, else the way lru names
    always_comb begin
        if (!valid0) begin
            victim = way0;
        end else if (!valid1) begin
            victim = way1;
        end else begin
            victim = way_t'(lru);
        end
    end

    // ram outputs hold until the next read, so they stay usable through the miss
    assign vway         = (state == dc_access) ? victim : victim_q;
    assign victim_tag   = (vway == way0) ? tag0 : tag1;
    assign victim_dirty = (vway == way0) ? (valid0 && dirty0) : (valid1 && dirty1);
    assign l2_wdata     = (vway == way0) ? line0 : line1;

    assign fill_way = victim_q;

    // write miss lands the cpu word in place, the hit pass then sets dirty
    always_comb begin
        fill_line = l2_rdata;
        if (wr_q) begin
            fill_line[a.f.offset*word_w +: word_w] = wdata;
        end
    end

    assign used_way = (state == dc_fill) ? victim_q : hit_way;
    assign lru_val  = (used_way == way0);  // point at the other way

    assign rdata = (state == dc_fill) ? pick_word(l2_rdata, a.f.offset)
                                      : pick_word(hit_line, a.f.offset);

    always_comb begin
        state_nx = state;
        stall    = 1'b1;
        tag_re   = 1'b0;
        fill_we  = 1'b0;
        word_we  = 1'b0;
        lru_we   = 1'b0;
        l2_req   = 1'b0;
        l2_wr    = 1'b0;
        l2_addr  = a.l.line;
        case (state)
            dc_idle: begin
                stall  = 1'b0;
                tag_re = access;
                if (access) begin
                    state_nx = dc_access;
                end
            end
            dc_access: begin
                if (hit) begin
                    lru_we = 1'b1;
                    if (wr_q) begin
                        word_we  = 1'b1;
                        state_nx = dc_write_hit;
                    end else begin
                        stall    = 1'b0;  // rdata valid now
                        state_nx = dc_idle;
                    end
                end else if (victim_dirty) begin
                    l2_addr = {victim_tag, a.f.index};
                    if (!l2_busy) begin
                        l2_req   = 1'b1;
                        l2_wr    = 1'b1;
                        state_nx = dc_write_back;
                    end else begin
                        state_nx = dc_wait_busy_dirty;
                    end
                end else if (!l2_busy) begin
                    l2_req   = 1'b1;
                    state_nx = dc_fill;
                end else begin
                    state_nx = dc_wait_busy_clean;
                end
            end
            dc_wait_busy_dirty: begin
                l2_addr = {victim_tag, a.f.index};
                if (!l2_busy) begin
                    l2_req   = 1'b1;
                    l2_wr    = 1'b1;
                    state_nx = dc_write_back;
                end
            end
            dc_write_back: begin
                if (l2_done) begin
                    state_nx = dc_wait_busy_clean;  // store still busy this cycle
                end
            end
            dc_wait_busy_clean: begin
                if (!l2_busy) begin
                    l2_req   = 1'b1;
                    state_nx = dc_fill;
                end
            end
            dc_fill: begin
                if (l2_rdy) begin
                    fill_we = 1'b1;
                    lru_we  = 1'b1;
                    if (wr_q) begin
                        tag_re   = 1'b1;  // reread sees the new line
                        state_nx = dc_access;
                    end else begin
                        stall    = 1'b0;  // word forwarded from l2_rdata
                        state_nx = dc_idle;
                    end
                end
            end
            dc_write_hit: begin
                stall    = 1'b0;
                state_nx = dc_idle;
            end
            default: begin
                state_nx = dc_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= dc_idle;
            wr_q     <= 1'b0;
            victim_q <= way0;
        end else begin
            state <= state_nx;
            if (state == dc_idle && access) begin
                wr_q <= wr;
            end
            if (state == dc_access && !hit) begin
                victim_q <= victim;
            end
        end
    end

endmodule

`default_nettype wire

//--- dcache_data_ram.sv
// ********************
// registered read; a fill in the read cycle is returned directly
// ********************
`default_nettype none

module dcache_data_ram #(
    parameter int sets = 256
) (
    input  wire                            clk,
    input  wire                            re,
    input  wire [dcache_pkg::index_w-1:0]  index,
    input  wire                            fill_we,
    input  wire dcache_pkg::way_t          fill_way,
    input  wire [dcache_pkg::line_w-1:0]   fill_line,
    input  wire                            word_we,
    input  wire dcache_pkg::way_t          hit_way,
    input  wire [dcache_pkg::offset_w-1:0] offset,
    input  wire [dcache_pkg::word_w-1:0]   wdata,
    output logic [dcache_pkg::line_w-1:0]  line0,
    output logic [dcache_pkg::line_w-1:0]  line1
);
    import dcache_pkg::*;

    logic [line_w-1:0] line_rd [2];

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [line_w-1:0] mem [sets];
        logic              fill_sel;
        logic              word_sel;

        assign fill_sel = fill_we && (fill_way == way_t'(w));
        assign word_sel = word_we && (hit_way == way_t'(w));

        always_ff @(posedge clk) begin
            if (fill_sel) begin
                mem[index] <= fill_line;  // whole line from l2
            end else if (word_sel) begin
                mem[index][offset*word_w +: word_w] <= wdata;  // one word lane
            end
            if (re) begin
                line_rd[w] <= fill_sel ? fill_line : mem[index];
            end
        end
    end

    assign line0 = line_rd[0];
    assign line1 = line_rd[1];

endmodule

`default_nettype wire

//--- dcache_pkg.sv
// ********************
// widths assume a 30-bit word address and 4-word lines
// ********************
`default_nettype none

package dcache_pkg;

    localparam int addr_w      = 30;  // cpu word address
    localparam int tag_w       = 20;
    localparam int index_w     = 8;
    localparam int offset_w    = 2;   // word in line
    localparam int line_addr_w = tag_w + index_w;
    localparam int line_w      = 128;
    localparam int word_w      = 32;

    typedef enum logic {
        way0,
        way1
    } way_t;

    typedef enum logic [2:0] {
        dc_idle,
        dc_access,            // tags and lines valid here
        dc_write_back,
        dc_wait_busy_clean,   // waiting to issue the fill read
        dc_wait_busy_dirty,   // waiting to issue the victim write
        dc_fill,
        dc_write_hit
    } dc_state_t;

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } addr_fields_t;

    typedef struct packed {
        logic [line_addr_w-1:0] line;  // tag and index as one field
        logic [offset_w-1:0]    offset;
    } addr_line_t;

    typedef union packed {
        addr_fields_t f;  // tag compare view
        addr_line_t   l;  // backing store view
    } dcache_addr_u;

endpackage

`default_nettype wire

//--- dcache_tag_ram.sv
// ********************
// reads are registered; a write in the same cycle as a read is
// returned by that read. valid and lru clear on reset, tags do not
// ********************
`default_nettype none

module dcache_tag_ram #(
    parameter int sets = 256
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           re,
    input  wire [dcache_pkg::index_w-1:0] index,
    input  wire [dcache_pkg::tag_w-1:0]   tag_in,
    input  wire                           fill_we,
    input  wire dcache_pkg::way_t         fill_way,
    input  wire                           word_we,
    input  wire dcache_pkg::way_t         hit_way,
    input  wire                           lru_we,
    input  wire                           lru_val,
    output logic [dcache_pkg::tag_w-1:0]  tag0,
    output logic [dcache_pkg::tag_w-1:0]  tag1,
    output logic                          valid0,
    output logic                          valid1,
    output logic                          dirty0,
    output logic                          dirty1,
    output logic                          lru
);
    import dcache_pkg::*;

    logic [tag_w-1:0] tag_rd [2];
    logic             valid_rd [2];
    logic             dirty_rd [2];
    logic [sets-1:0]  lru_v;  // 1 names way1 as next victim

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [tag_w-1:0] tag_mem [sets];
        logic             dirty_mem [sets];
        logic [sets-1:0]  valid_v;  // flops, so reset needs no sweep
        logic             fill_sel;
        logic             word_sel;

        assign fill_sel = fill_we && (fill_way == way_t'(w));
        assign word_sel = word_we && (hit_way == way_t'(w));

        always_ff @(posedge clk) begin
            if (rst) begin
                valid_v <= '0;
            end else if (fill_sel) begin
                valid_v[index] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (fill_sel) begin
                tag_mem[index]   <= tag_in;
                dirty_mem[index] <= 1'b0;  // fresh line is clean
            end else if (word_sel) begin
                dirty_mem[index] <= 1'b1;
            end
            if (re) begin
                tag_rd[w]   <= fill_sel ? tag_in : tag_mem[index];
                valid_rd[w] <= fill_sel || valid_v[index];
                dirty_rd[w] <= fill_sel ? 1'b0 : (word_sel || dirty_mem[index]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_v <= '0;
        end else if (lru_we) begin
            lru_v[index] <= lru_val;
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            lru <= lru_we ? lru_val : lru_v[index];
        end
    end

    assign tag0   = tag_rd[0];
    assign tag1   = tag_rd[1];
    assign valid0 = valid_rd[0];
    assign valid1 = valid_rd[1];
    assign dirty0 = dirty_rd[0];
    assign dirty1 = dirty_rd[1];

endmodule

`default_nettype wire

//--- dcache_top.sv
// ********************
// sets must match index_w in dcache_pkg
// ********************
`default_nettype none

module dcache_top #(
    parameter int sets       = 256,
    parameter int lines_log2 = 10,
    parameter int l2_latency = 8
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          access,
    input  wire                          wr,
    input  wire [dcache_pkg::addr_w-1:0] addr,
    input  wire [dcache_pkg::word_w-1:0] wdata,
    output logic                         stall,
    output logic [dcache_pkg::word_w-1:0] rdata
);
    import dcache_pkg::*;

    logic                   tag_re;
    logic [index_w-1:0]     index;
    logic [offset_w-1:0]    offset;
    logic [tag_w-1:0]       tag_in;
    logic [tag_w-1:0]       tag0;
    logic [tag_w-1:0]       tag1;
    logic                   valid0;
    logic                   valid1;
    logic                   dirty0;
    logic                   dirty1;
    logic                   lru;
    logic [line_w-1:0]      line0;
    logic [line_w-1:0]      line1;
    logic                   fill_we;
    way_t                   fill_way;
    logic [line_w-1:0]      fill_line;
    logic                   word_we;
    way_t                   hit_way;
    logic                   lru_we;
    logic                   lru_val;
    logic                   l2_req;
    logic                   l2_wr;
    logic [line_addr_w-1:0] l2_addr;
    logic [line_w-1:0]      l2_wdata;
    logic                   l2_busy;
    logic                   l2_rdy;
    logic                   l2_done;
    logic [line_w-1:0]      l2_rdata;

    dcache_ctrl u_ctrl (.*);

    dcache_tag_ram #(.sets(sets)) u_tag_ram (.*, .re(tag_re));

    dcache_data_ram #(.sets(sets)) u_data_ram (.*, .re(tag_re));

    l2_backing_store #(
        .lines_log2 (lines_log2),
        .l2_latency (l2_latency)
    ) u_l2 (
        .clk   (clk),
        .rst   (rst),
        .req   (l2_req),
        .wr    (l2_wr),
        .addr  (l2_addr),
        .wdata (l2_wdata),
        .busy  (l2_busy),
        .rdy   (l2_rdy),
        .done  (l2_done),
        .rdata (l2_rdata)
    );

endmodule

`default_nettype wire

//--- l2_backing_store.sv
// ********************
// l2_latency >= 1; only the low lines_log2 line-address bits are
// decoded, so higher addresses alias
// ********************
`default_nettype none

module l2_backing_store #(
    parameter int lines_log2 = 10,
    parameter int l2_latency = 8
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                req,
    input  wire                                wr,
    input  wire [dcache_pkg::line_addr_w-1:0]  addr,
    input  wire [dcache_pkg::line_w-1:0]       wdata,
    output logic                               busy,
    output logic                               rdy,
    output logic                               done,
    output logic [dcache_pkg::line_w-1:0]      rdata
);
    import dcache_pkg::*;

    localparam int cnt_w = $clog2(l2_latency + 1);

    logic [line_w-1:0]     mem [2**lines_log2] = '{default: '0};
    logic [lines_log2-1:0] idx;
    logic [cnt_w-1:0]      cnt;      // cycles left, 0 when free
    logic                  pend_wr;
    logic                  accept;
    logic                  last;

    assign idx    = addr[lines_log2-1:0];
    assign accept = req && !busy;
    assign last   = (cnt == cnt_w'(1));

    assign busy = (cnt != '0);
    assign rdy  = last && !pend_wr;  // l2_latency cycles after req
    assign done = last && pend_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            pend_wr <= 1'b0;
        end else if (accept) begin
            cnt     <= cnt_w'(l2_latency);
            pend_wr <= wr;
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    // the array changes only at accept, so read data can be taken early
    always_ff @(posedge clk) begin
        if (accept) begin
            if (wr) begin
                mem[idx] <= wdata;
            end else begin
                rdata <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

//--- src.f
dcache_pkg.sv
dcache_tag_ram.sv
dcache_data_ram.sv
dcache_ctrl.sv
l2_backing_store.sv
dcache_top.sv
tb_dcache.sv

//--- tb_dcache.sv
// ********************
// model covers only the words the backing store decodes; tags stay
// below 4 so no two cache lines share a store line
// ********************
`default_nettype none

module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    localparam int store_lines_log2 = 10;
    localparam int model_words      = 4 << store_lines_log2;
    localparam int timeout_cycles   = 200;

    logic              clk;
    logic              rst;
    logic              access;
    logic              wr;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] wdata;
    logic              stall;
    logic [word_w-1:0] rdata;

    logic [31:0]       seed;
    logic [word_w-1:0] model [model_words];
    int                checks;
    int                errors;
    int                test_start;
    logic              timed_out;
    logic [word_w-1:0] got;     // rdata seen when stall fell
    int                cycles;  // cycles from access to stall low

    dcache_top #(
        .sets       (256),
        .lines_log2 (store_lines_log2),
        .l2_latency (8)
    ) DUT (
        .clk    (clk),
        .rst    (rst),
        .access (access),
        .wr     (wr),
        .addr   (addr),
        .wdata  (wdata),
        .stall  (stall),
        .rdata  (rdata)
    );

    always #20 clk = ~clk;

    function automatic logic [15:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[31:16];  // low bits of the lcg cycle too fast
    endfunction

    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    function automatic logic [addr_w-1:0] make_addr(input int tag, input int idx, input int off);
        dcache_addr_u u;
        u          = '0;
        u.f.tag    = tag_w'(tag);
        u.f.index  = index_w'(idx);
        u.f.offset = offset_w'(off);
        return u;
    endfunction

    function automatic logic [addr_w-1:0] rand_addr(input int idx_range);
        return make_addr(lcg_next() % 4, lcg_next() % idx_range, lcg_next() % 4);
    endfunction

    // store decodes the low line-address bits, the model does the same
    function automatic int model_slot(input logic [addr_w-1:0] a);
        dcache_addr_u u;
        u = a;
        return {u.l.line[store_lines_log2-1:0], u.l.offset};
    endfunction

    task automatic check_value(input string name, input logic [31:0] val, input logic [31:0] exp);
        checks++;
        if (val !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, val, exp);
        end
    endtask

    task automatic drive_access(input logic is_wr, input logic [addr_w-1:0] a,
                                input logic [word_w-1:0] d);
        if (timed_out) begin
            return;
        end
        @(posedge clk);
        access <= 1'b1;
        wr     <= is_wr;
        addr   <= a;
        wdata  <= d;
        @(posedge clk);
        access <= 1'b0;  // one-cycle pulse
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (stall && cycles < timeout_cycles);
        got = rdata;
        if (stall) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: stall still high %0d cycles after access to %h at %0t",
                     timeout_cycles, a, $time);
        end else if (is_wr) begin
            model[model_slot(a)] = d;
        end
    endtask

    task automatic read_check(input logic [addr_w-1:0] a);
        drive_access(1'b0, a, '0);
        if (!timed_out) begin
            check_value($sformatf("rdata[%h]", a), got, model[model_slot(a)]);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        logic [addr_w-1:0] a;
        logic [word_w-1:0] d;
        int                idx;
        int                t;
        clk        = 1'b0;
        rst        = 1'b1;
        access     = 1'b0;
        wr         = 1'b0;
        addr       = '0;
        wdata      = '0;
        seed       = 32'd22;
        checks     = 0;
        errors     = 0;
        test_start = 0;
        timed_out  = 1'b0;
        got        = '0;
        cycles     = 0;
        for (int i = 0; i < model_words; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // idle after reset, then cold reads
        repeat (10) begin
            @(negedge clk);
            check_value("stall", stall, 32'd0);
        end
        repeat (4) begin
            a = rand_addr(256);
            drive_access(1'b0, a, '0);
            check_value($sformatf("rdata[%h]", a), got, 32'd0);
        end
        end_test("reset_idle");

        for (int i = 0; i < 8; i++) begin
            a = rand_addr(256);
            d = rand_word();
            drive_access(1'b1, a, d);
            drive_access(1'b0, a, '0);
            check_value($sformatf("rdata[%h]", a), got, d);
            check_value("stall_cycles", cycles, 32'd1);  // read hit timing
        end
        end_test("write_then_read");

        for (int k = 0; k < 2; k++) begin
            idx = lcg_next() % 256;
            for (int tg = 0; tg < 4; tg++) begin
                for (int off = 0; off < 4; off++) begin
                    drive_access(1'b1, make_addr(tg, idx, off), rand_word());
                end
            end
            for (int tg = 0; tg < 4; tg++) begin
                for (int off = 0; off < 4; off++) begin
                    read_check(make_addr(tg, idx, off));
                end
            end
        end
        end_test("lru_eviction");

        idx = lcg_next() % 256;
        t   = lcg_next() % 4;
        for (int off = 0; off < 4; off++) begin
            drive_access(1'b1, make_addr(t, idx, off), rand_word());
        end
        drive_access(1'b1, make_addr((t + 1) % 4, idx, 0), rand_word());  // push t out
        drive_access(1'b1, make_addr((t + 2) % 4, idx, 0), rand_word());
        drive_access(1'b1, make_addr(t, idx, 2), rand_word());
        checks++;
        if (!timed_out && cycles <= 2) begin
            errors++;
            $display("Mismatch at %0t: stall_cycles = %0d, expected more than 2",
                     $time, cycles);
        end
        for (int off = 0; off < 4; off++) begin
            read_check(make_addr(t, idx, off));
        end
        end_test("write_miss_allocate");

        for (int i = 0; i < 400; i++) begin
            a = rand_addr(4);  // small window, heavy set conflicts
            if (lcg_next() % 2 == 1) begin
                drive_access(1'b1, a, rand_word());
            end else begin
                read_check(a);
            end
        end
        end_test("random_mix");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
